/* dv/spi_flash_emu_assert.sv */
// ******************************
// Emulator protocol checks
// ******************************
`timescale 1ns/1ps

module spi_flash_emu_assert (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic cs_n,
	input logic miso_oe,
	input logic cs_active,
	input logic log_push
);

	// access phase only inside a selected transfer
	penable_in_psel: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> psel) else $error("penable high without psel");

	// error response only on the completing cycle
	pslverr_with_pready: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> pready) else $error("pslverr high without pready");

	// allow the pin synchronizer a few clocks after deselect
	oe_off_when_deselected: assert property (@(posedge clk) disable iff (!rst_n)
		cs_n [*4] |-> !miso_oe) else $error("miso_oe high with cs_n high");

	// log words only leave after chip select rises
	no_push_while_selected: assert property (@(posedge clk) disable iff (!rst_n)
		cs_active |-> !log_push) else $error("log_push while selected");

endmodule

/* dv/spi_flash_emu_tb.sv */
// ******************************
// SPI flash emulator testbench
// ******************************
`timescale 1ns/1ps

module spi_flash_emu_tb
	import flash_emu_pkg::*, host_map_pkg::*;
;

	localparam int img_bits = 10;
	localparam int img_size = 2 ** img_bits;
	localparam int log_depth = 8;
	localparam int idle_cycles = 64;
	localparam logic [23:0] jedec = 24'hef4018;
	// SPI half period in system clocks
	localparam int half = 10;
	localparam int spi_bytes_max = 400;
	localparam int watchdog_clks = img_size * 8 + spi_bytes_max * 16 * half + 10000;

	logic clk = 1'b0;
	logic rst_n;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic sclk;
	logic cs_n;
	logic mosi;
	logic miso;
	logic miso_oe;

	logic [7:0] ref_mem [img_size];
	logic [31:0] rng_state = 32'h7cc5b504;
	logic [7:0] tx_q[$];
	logic [7:0] rx_q[$];
	logic [7:0] want_q[$];
	logic [7:0] got_q[$];
	string tag_q[$];
	int oe_high_cnt;
	int err_cnt = 0;

	spi_flash_emu #(
		.IMG_ADDR_BITS(img_bits),
		.LOG_DEPTH(log_depth),
		.IDLE_CYCLES(idle_cycles),
		.JEDEC_ID(jedec)
	) i_spi_flash_emu (
		.clk(clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.miso_oe(miso_oe)
	);

	bind spi_flash_emu spi_flash_emu_assert i_assert (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pready(pready),
		.pslverr(pslverr),
		.cs_n(cs_n),
		.miso_oe(miso_oe),
		.cs_active(cs_active),
		.log_push(log_push)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// expected image byte, address wraps modulo the image size
	function automatic logic [7:0] read_ref(input logic [23:0] addr, input int idx);
		return ref_mem[img_bits'(addr + 24'(idx))];
	endfunction

	// id bytes MSB first, then filler forever
	function automatic logic [7:0] id_ref(input int idx);
		if (idx < 3)
			return jedec[23 - 8 * idx -: 8];
		return idle_byte;
	endfunction

	// first four bytes sent in arrival order, missing ones zero
	function automatic flash_cmd_t log_ref(input logic [7:0] sent[$]);
		flash_cmd_t c;
		c = '0;
		for (int i = 0; i < 4 && i < sent.size(); i++)
			c.bytes[i] = sent[i];
		return c;
	endfunction

	task automatic abort_run(input string msg);
		err_cnt++;
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_log(input string name, input flash_cmd_t exp, input flash_cmd_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %h/%h, actual %h/%h", name,
				exp.fields.opcode, exp.fields.addr, act.fields.opcode, act.fields.addr));
	endtask

	task automatic check_status(input string name, input logic [status_level_bits-1:0] lvl,
		input logic [status_ovf_bits-1:0] ovf, input logic [31:0] act);
		if (act[status_level_bits-1:0] !== lvl || act[status_level_bits +: status_ovf_bits] !== ovf)
			abort_run($sformatf("FAILED %s: expected level %0d ovf %0d, actual %h", name,
				lvl, ovf, act));
	endtask

	// comparing process, one byte per clock
	always @(negedge clk) begin
		if (want_q.size() != 0 && got_q.size() != 0)
			check_byte(tag_q.pop_front(), want_q.pop_front(), got_q.pop_front());
	end

	initial begin
		repeat (watchdog_clks) @(posedge clk);
		abort_run("timeout: the testbench did not finish in the expected time");
	end

	task automatic wait_clks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic drain_compares();
		while (want_q.size() != 0)
			wait_clks(1);
	endtask

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wd,
		output logic [31:0] rd, output logic err);
		paddr = addr;
		pwrite = wr;
		pwdata = wd;
		psel = 1'b1;
		penable = 1'b0;
		wait_clks(1);
		penable = 1'b1;
		// sample mid-cycle, stable up to the completing edge
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		rd = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wd);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, wd, rd, err);
		if (err)
			abort_run($sformatf("unexpected pslverr on write to offset %h", addr));
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rd);
		logic err;
		apb_xfer(1'b0, addr, '0, rd, err);
		if (err)
			abort_run($sformatf("unexpected pslverr on read of offset %h", addr));
	endtask

	task automatic pop_log_check(input string name, input flash_cmd_t exp);
		logic [31:0] d;
		apb_read(reg_log, d);
		check_log(name, exp, flash_cmd_t'(d));
	endtask

	// mode 0, mosi set while sclk low, miso sampled at the rising edge
	task automatic spi_bit(input logic b, output logic r);
		mosi = b;
		wait_clks(half);
		r = miso;
		if (miso_oe)
			oe_high_cnt++;
		sclk = 1'b1;
		wait_clks(half);
		sclk = 1'b0;
	endtask

	task automatic spi_byte(input logic [7:0] t, output logic [7:0] r);
		for (int b = 7; b >= 0; b--)
			spi_bit(t[b], r[b]);
	endtask

	// chip select low with sclk idle, the sequencer owns the RAM meanwhile
	task automatic hold_select(input int n);
		cs_n = 1'b0;
		wait_clks(n);
		cs_n = 1'b1;
	endtask

	// whole transaction from tx_q, received bytes into rx_q
	task automatic spi_transfer();
		logic [7:0] r;
		rx_q = {};
		oe_high_cnt = 0;
		cs_n = 1'b0;
		wait_clks(half);
		foreach (tx_q[i]) begin
			spi_byte(tx_q[i], r);
			rx_q.push_back(r);
		end
		wait_clks(half);
		cs_n = 1'b1;
		wait_clks(2 * half);
	endtask

	task automatic run_read(input logic [23:0] addr, input int n, input logic oe_exp);
		tx_q = {op_read, addr[23:16], addr[15:8], addr[7:0]};
		for (int i = 0; i < n; i++)
			tx_q.push_back(8'h00);
		spi_transfer();
		for (int i = 0; i < n; i++) begin
			want_q.push_back(read_ref(addr, i));
			got_q.push_back(rx_q[4 + i]);
			tag_q.push_back($sformatf("read %h byte %0d", addr, i));
		end
		drain_compares();
		if (oe_exp && oe_high_cnt != 8 * tx_q.size())
			abort_run("miso_oe dropped during an enabled read");
		if (!oe_exp && oe_high_cnt != 0)
			abort_run("miso_oe went high while enable was cleared");
		pop_log_check("read log", log_ref(tx_q));
	endtask

	initial begin
		logic [31:0] d;
		logic err;
		logic r;
		int n;
		int cnt;
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		sclk = 1'b0;
		cs_n = 1'b1;
		mosi = 1'b0;
		wait_clks(10);
		rst_n = 1'b1;
		wait_clks(2);

		// image load and readback
		for (int a = 0; a < img_size; a++) begin
			rng_state = xorshift(rng_state);
			ref_mem[a] = rng_state[7:0] ^ 8'(a >> 3);
		end
		apb_write(reg_img_addr, 0);
		for (int a = 0; a < img_size; a++)
			apb_write(reg_img_data, {24'h0, ref_mem[a]});
		apb_write(reg_img_addr, 0);
		for (int a = 0; a < img_size; a++) begin
			// some reads start while selected and must wait for the grant
			if (a % 256 == 0) begin
				fork
					hold_select(3 * half);
					begin
						wait_clks(4);
						apb_read(reg_img_data, d);
						if (!cs_n)
							abort_run("image read completed while chip select was low");
					end
				join
			end else begin
				apb_read(reg_img_data, d);
			end
			check_byte($sformatf("image %0d", a), ref_mem[a], d[7:0]);
		end
		apb_write(reg_ctrl, 1);

		// random reads, then one across the end of the image
		for (int k = 0; k < 10; k++) begin
			rng_state = xorshift(rng_state);
			n = 1 + int'(rng_state[31:24] % 20);
			run_read(rng_state[23:0], n, 1'b1);
		end
		run_read(24'h2003fc, 12, 1'b1);

		// JEDEC id then filler, unknown opcode all ones
		tx_q = {op_read_id, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
		spi_transfer();
		for (int i = 1; i < 6; i++)
			check_byte($sformatf("jedec byte %0d", i - 1), id_ref(i - 1), rx_q[i]);
		pop_log_check("jedec log", log_ref(tx_q));
		tx_q = {8'ha5, 8'h00, 8'h00};
		spi_transfer();
		check_byte("unknown byte 1", idle_byte, rx_q[1]);
		check_byte("unknown byte 2", idle_byte, rx_q[2]);
		pop_log_check("unknown log", log_ref(tx_q));

		// overflow the log
		apb_read(reg_status, d);
		check_status("status empty", 0, 0, d);
		for (int k = 0; k < log_depth + 3; k++) begin
			tx_q = {8'(8'h40 + k)};
			spi_transfer();
		end
		apb_read(reg_status, d);
		check_status("status full", log_depth, 3, d);
		for (int k = 0; k < log_depth; k++) begin
			tx_q = {8'(8'h40 + k)};
			pop_log_check($sformatf("overflow log %0d", k), log_ref(tx_q));
		end
		apb_read(reg_log, d);
		check_log("empty log", '0, flash_cmd_t'(d));
		apb_read(reg_status, d);
		check_status("status drained", 0, 3, d);

		// disabled output and bus errors
		apb_write(reg_ctrl, 0);
		run_read(24'h000123, 4, 1'b0);
		apb_xfer(1'b0, 8'h14, '0, d, err);
		if (!err)
			abort_run("no pslverr for a read of an unknown offset");
		apb_xfer(1'b1, reg_status, 32'h1, d, err);
		if (!err)
			abort_run("no pslverr for a write to the status register");
		apb_write(reg_ctrl, 1);

		// sclk stops mid burst with chip select low
		tx_q = {op_read, 8'h00, 8'h00, 8'h64};
		cs_n = 1'b0;
		wait_clks(half);
		for (int b = 0; b < 51; b++)
			spi_bit(b < 32 ? tx_q[b / 8][7 - b % 8] : 1'b0, r);
		if (!miso_oe)
			abort_run("miso_oe low before the SPI clock stopped");
		cnt = 0;
		while (miso_oe && cnt < idle_cycles + 4) begin
			wait_clks(1);
			cnt++;
		end
		if (miso_oe)
			abort_run("miso_oe still high after the SPI clock stalled");
		cs_n = 1'b1;
		wait_clks(2 * half);
		pop_log_check("stall log", log_ref(tx_q));

		drain_compares();
		if (err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* source/flash_emu_pkg.sv */
// ******************************
// SPI flash side definitions
// ******************************

package flash_emu_pkg;

	// standard single-lane read, three address bytes then data
	localparam logic [7:0] op_read = 8'h03;

	// JEDEC identifier read, three id bytes then filler
	localparam logic [7:0] op_read_id = 8'h9f;

	// MISO filler when the emulator has nothing to send
	// matches an undriven line with a pull-up
	localparam logic [7:0] idle_byte = 8'hff;

	// command word as logged to the host
	// fields view puts the opcode in the top byte
	// bytes view is indexed in arrival order, bytes[0] is the opcode
	// so the sequencer can drop each received byte straight into place
	typedef union packed {
		struct packed {
			logic [7:0] opcode;
			logic [23:0] addr;
		} fields;
		logic [0:3][7:0] bytes;
	} flash_cmd_t;

endpackage

/* source/flash_sequencer.sv */
// ******************************
// Flash command sequencer
// ******************************
`timescale 1ns/1ps

module flash_sequencer
	import flash_emu_pkg::*;
#(
	parameter int IMG_ADDR_BITS = 10,
	parameter logic [23:0] JEDEC_ID = 24'hef4018
) (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	input logic cs_active,
	input logic cs_rise,
	input logic stall,
	input logic [7:0] ram_rdata,
	output logic [7:0] tx_byte,
	output logic tx_load,
	output logic ram_rd,
	output logic [IMG_ADDR_BITS-1:0] ram_addr,
	output logic miso_oe,
	output flash_cmd_t log_word,
	output logic log_push
);

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_opcode = 3'd1;
	localparam logic [2:0] st_address = 3'd2;
	localparam logic [2:0] st_stream = 3'd3;
	localparam logic [2:0] st_id = 3'd4;
	localparam logic [2:0] st_ignore = 3'd5;

	logic [2:0] state;
	// bytes received in this command, saturates at 4
	logic [2:0] byte_cnt;
	flash_cmd_t cmd;
	logic [23:0] id_sr;
	logic [23:0] rx_addr;
	// two-stage fetch pipe, ram address then ram data
	logic fetch_q1;
	logic fetch_q2;
	logic id_load;

	// full address once the third address byte is on rx_byte
	assign rx_addr = {cmd.fields.addr[23:8], rx_byte};
	assign log_word = cmd;

	// image data wins over the id path, they never overlap
	assign tx_byte = fetch_q2 ? ram_rdata : id_sr[23:16];
	assign tx_load = fetch_q2 | id_load;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			byte_cnt <= 3'd0;
			ram_rd <= 1'b0;
			fetch_q1 <= 1'b0;
			fetch_q2 <= 1'b0;
			id_load <= 1'b0;
			miso_oe <= 1'b0;
			log_push <= 1'b0;
		end else begin
			fetch_q1 <= 1'b0;
			fetch_q2 <= fetch_q1;
			id_load <= 1'b0;
			log_push <= 1'b0;
			miso_oe <= enable && cs_active && !stall;
			if (rx_valid && byte_cnt != 3'd4)
				byte_cnt <= byte_cnt + 3'd1;
			case (state)
				st_idle: begin
					// selected, take the RAM for the whole transaction
					if (cs_active) begin
						state <= st_opcode;
						byte_cnt <= 3'd0;
						ram_rd <= 1'b1;
					end
				end
				st_opcode: begin
					if (rx_valid) begin
						if (rx_byte == op_read) begin
							state <= st_address;
						end else if (rx_byte == op_read_id) begin
							state <= st_id;
							id_load <= 1'b1;
						end else begin
							state <= st_ignore;
						end
					end
				end
				st_address: begin
					// last address byte, first fetch goes out now
					if (rx_valid && byte_cnt == 3'd3) begin
						state <= st_stream;
						fetch_q1 <= 1'b1;
					end
				end
				st_stream: begin
					// refill for the byte after the one now shifting
					if (rx_valid)
						fetch_q1 <= 1'b1;
				end
				st_id: begin
					if (rx_valid)
						id_load <= 1'b1;
				end
				default: begin
				end
			endcase
			// host went quiet, stop feeding the shifter
			if (stall && state != st_idle)
				state <= st_ignore;
			if (cs_rise) begin
				state <= st_idle;
				ram_rd <= 1'b0;
				log_push <= (cmd != '0);
			end
		end
	end

	always_ff @(posedge clk) begin
		// opcode and up to three address bytes, unused bytes stay zero
		if (state == st_idle && cs_active)
			cmd <= '0;
		else if (rx_valid && byte_cnt != 3'd4)
			cmd.bytes[byte_cnt[1:0]] <= rx_byte;

		// id bytes leave from the top, filler shifts in behind
		if (state == st_opcode && rx_valid)
			id_sr <= JEDEC_ID;
		else if (id_load)
			id_sr <= {id_sr[15:0], idle_byte};

		// address wraps modulo the image size
		if (state == st_address && rx_valid && byte_cnt == 3'd3)
			ram_addr <= rx_addr[IMG_ADDR_BITS-1:0];
		else if (state == st_stream && rx_valid)
			ram_addr <= ram_addr + 1'b1;
	end

endmodule

/* source/host_apb_regs.sv */
// ******************************
// Host APB registers
// ******************************
`timescale 1ns/1ps

module host_apb_regs
	import host_map_pkg::*;
#(
	parameter int IMG_ADDR_BITS = 10,
	parameter int LOG_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic [apb_addr_bits-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apb_data_bits-1:0] pwdata,
	input logic [31:0] log_word,
	input logic log_push,
	input logic [7:0] ram_rdata,
	input logic host_gnt,
	output logic [apb_data_bits-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic enable,
	output logic host_req,
	output logic host_we,
	output logic [IMG_ADDR_BITS-1:0] host_addr,
	output logic [7:0] host_wdata
);

	localparam int ptr_bits = (LOG_DEPTH > 1) ? $clog2(LOG_DEPTH) : 1;
	localparam int lvl_bits = $clog2(LOG_DEPTH + 1);

	logic access;
	logic xfer;
	logic img_sel;
	logic known;
	logic ro_write;
	logic img_rd_q;
	logic log_pop;
	logic log_wr;
	logic [31:0] log_mem [LOG_DEPTH];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [lvl_bits-1:0] level;
	logic [status_ovf_bits-1:0] ovf_cnt;
	logic [IMG_ADDR_BITS-1:0] img_ptr;

	function automatic logic [ptr_bits-1:0] ptr_next(input logic [ptr_bits-1:0] p);
		if (p == ptr_bits'(LOG_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign access = psel & penable;
	assign img_sel = (paddr == reg_img_data);
	// image data waits for the grant, reads take one more cycle for the RAM
	assign pready = !img_sel || (pwrite ? host_gnt : img_rd_q);
	assign xfer = access & pready;
	assign host_req = access & img_sel & host_gnt & (pwrite | ~img_rd_q);
	assign host_we = pwrite;
	assign host_addr = img_ptr;
	assign host_wdata = pwdata[7:0];

	assign known = paddr inside {reg_ctrl, reg_img_addr, reg_img_data, reg_log, reg_status};
	assign ro_write = pwrite & ((paddr == reg_log) | (paddr == reg_status));
	assign pslverr = access & (~known | ro_write);

	// empty log reads as zero and pops nothing
	assign log_pop = xfer & ~pwrite & (paddr == reg_log) & (level != '0);
	// full log drops the new word
	assign log_wr = log_push & (level != lvl_bits'(LOG_DEPTH));

	always_comb begin
		prdata = '0;
		case (paddr)
			reg_ctrl: prdata[ctrl_enable_bit] = enable;
			reg_img_addr: prdata[IMG_ADDR_BITS-1:0] = img_ptr;
			reg_img_data: prdata[7:0] = ram_rdata;
			reg_log: begin
				if (level != '0)
					prdata = log_mem[rd_ptr];
			end
			reg_status: begin
				prdata[status_level_bits-1:0] = status_level_bits'(level);
				prdata[status_level_bits +: status_ovf_bits] = ovf_cnt;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			img_rd_q <= 1'b0;
			enable <= 1'b0;
			img_ptr <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			ovf_cnt <= '0;
		end else begin
			// RAM read issued this cycle, data is on ram_rdata next cycle
			img_rd_q <= access & img_sel & ~pwrite & host_gnt & ~img_rd_q;
			if (xfer && pwrite && paddr == reg_ctrl)
				enable <= pwdata[ctrl_enable_bit];
			// image pointer post-increments on every data access
			if (xfer && pwrite && paddr == reg_img_addr)
				img_ptr <= pwdata[IMG_ADDR_BITS-1:0];
			else if (xfer && img_sel)
				img_ptr <= img_ptr + 1'b1;
			if (log_wr)
				wr_ptr <= ptr_next(wr_ptr);
			if (log_pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (log_wr && !log_pop)
				level <= level + 1'b1;
			else if (log_pop && !log_wr)
				level <= level - 1'b1;
			// overflow count saturates
			if (log_push && !log_wr && ovf_cnt != '1)
				ovf_cnt <= ovf_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (log_wr)
			log_mem[wr_ptr] <= log_word;
	end

endmodule

/* source/host_map_pkg.sv */
// ******************************
// APB register map
// ******************************

package host_map_pkg;

	// APB bus widths
	localparam int apb_addr_bits = 8;
	localparam int apb_data_bits = 32;

	// register offsets
	localparam logic [apb_addr_bits-1:0] reg_ctrl = 8'h00;
	localparam logic [apb_addr_bits-1:0] reg_img_addr = 8'h04;
	localparam logic [apb_addr_bits-1:0] reg_img_data = 8'h08;
	localparam logic [apb_addr_bits-1:0] reg_log = 8'h0c;
	localparam logic [apb_addr_bits-1:0] reg_status = 8'h10;

	// control register fields
	localparam int ctrl_enable_bit = 0;

	// status register, log level in the low field
	// overflow count sits directly above it
	localparam int status_level_bits = 8;
	localparam int status_ovf_bits = 8;

endpackage

/* source/image_ram.sv */
// ******************************
// Flash image RAM
// ******************************
`timescale 1ns/1ps

module image_ram #(
	parameter int IMG_ADDR_BITS = 10
) (
	input logic clk,
	input logic seq_rd,
	input logic [IMG_ADDR_BITS-1:0] seq_addr,
	input logic host_req,
	input logic host_we,
	input logic [IMG_ADDR_BITS-1:0] host_addr,
	input logic [7:0] host_wdata,
	output logic [7:0] rdata,
	output logic host_gnt
);

	logic [7:0] mem [2**IMG_ADDR_BITS];

	// sequencer holds seq_rd for the whole time chip select is low
	// host only gets the port outside that window
	assign host_gnt = !seq_rd;

	always_ff @(posedge clk) begin
		if (seq_rd) begin
			rdata <= mem[seq_addr];
		end else if (host_req) begin
			if (host_we)
				mem[host_addr] <= host_wdata;
			// read-before-write, host writes ignore rdata
			rdata <= mem[host_addr];
		end
	end

endmodule

/* source/spi_flash_emu.sv */
// ******************************
// SPI NOR flash emulator
// ******************************
`timescale 1ns/1ps

module spi_flash_emu
	import host_map_pkg::*;
#(
	parameter int IMG_ADDR_BITS = 10,
	parameter int LOG_DEPTH = 8,
	parameter int IDLE_CYCLES = 64,
	parameter logic [23:0] JEDEC_ID = 24'hef4018
) (
	input logic clk,
	input logic rst_n,
	input logic [apb_addr_bits-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apb_data_bits-1:0] pwdata,
	output logic [apb_data_bits-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic sclk,
	input logic cs_n,
	input logic mosi,
	output logic miso,
	output logic miso_oe
);

	// shifter to sequencer
	logic [7:0] rx_byte;
	logic rx_valid;
	logic cs_active;
	logic cs_rise;
	logic sclk_edge;
	logic [7:0] tx_byte;
	logic tx_load;
	logic stall;
	// image RAM ports
	logic ram_rd;
	logic [IMG_ADDR_BITS-1:0] ram_addr;
	logic [7:0] ram_rdata;
	logic host_req;
	logic host_we;
	logic [IMG_ADDR_BITS-1:0] host_addr;
	logic [7:0] host_wdata;
	logic host_gnt;
	// log and control toward the host
	logic [31:0] log_word;
	logic log_push;
	logic enable;

	spi_shifter i_spi_shifter (
		.clk(clk),
		.rst_n(rst_n),
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.tx_byte(tx_byte),
		.tx_load(tx_load),
		.miso(miso),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.cs_active(cs_active),
		.cs_rise(cs_rise),
		.sclk_edge(sclk_edge)
	);

	spi_idle_timer #(
		.IDLE_CYCLES(IDLE_CYCLES)
	) i_spi_idle_timer (
		.clk(clk),
		.rst_n(rst_n),
		.sclk_edge(sclk_edge),
		.cs_active(cs_active),
		.stall(stall)
	);

	flash_sequencer #(
		.IMG_ADDR_BITS(IMG_ADDR_BITS),
		.JEDEC_ID(JEDEC_ID)
	) i_flash_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.cs_active(cs_active),
		.cs_rise(cs_rise),
		.stall(stall),
		.ram_rdata(ram_rdata),
		.tx_byte(tx_byte),
		.tx_load(tx_load),
		.ram_rd(ram_rd),
		.ram_addr(ram_addr),
		.miso_oe(miso_oe),
		.log_word(log_word),
		.log_push(log_push)
	);

	image_ram #(
		.IMG_ADDR_BITS(IMG_ADDR_BITS)
	) i_image_ram (
		.clk(clk),
		.seq_rd(ram_rd),
		.seq_addr(ram_addr),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.rdata(ram_rdata),
		.host_gnt(host_gnt)
	);

	host_apb_regs #(
		.IMG_ADDR_BITS(IMG_ADDR_BITS),
		.LOG_DEPTH(LOG_DEPTH)
	) i_host_apb_regs (
		.clk(clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.log_word(log_word),
		.log_push(log_push),
		.ram_rdata(ram_rdata),
		.host_gnt(host_gnt),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.enable(enable),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata)
	);

endmodule

/* source/spi_idle_timer.sv */
// ******************************
// SPI clock stall timer
// ******************************
`timescale 1ns/1ps

module spi_idle_timer #(
	parameter int IDLE_CYCLES = 64
) (
	input logic clk,
	input logic rst_n,
	input logic sclk_edge,
	input logic cs_active,
	output logic stall
);

	localparam int cnt_bits = $clog2(IDLE_CYCLES + 1);
	// stall lands IDLE_CYCLES clocks after the edge
	localparam logic [cnt_bits-1:0] reload = cnt_bits'(IDLE_CYCLES - 1);

	logic [cnt_bits-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= reload;
			stall <= 1'b0;
		end else if (!cs_active) begin
			// deselect clears the stall and rearms
			cnt <= reload;
			stall <= 1'b0;
		end else if (sclk_edge) begin
			cnt <= reload;
		end else if (cnt == '0) begin
			// sticky until chip select rises
			stall <= 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

endmodule

/* source/spi_shifter.sv */
// ******************************
// SPI target shifter
// ******************************
`timescale 1ns/1ps

module spi_shifter
	import flash_emu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic sclk,
	input logic cs_n,
	input logic mosi,
	input logic [7:0] tx_byte,
	input logic tx_load,
	output logic miso,
	output logic [7:0] rx_byte,
	output logic rx_valid,
	output logic cs_active,
	output logic cs_rise,
	output logic sclk_edge
);

	// [1] is the synchronized pin, [2] the previous sample for edges
	logic [2:0] sclk_q;
	logic [2:0] cs_q;
	logic [1:0] mosi_q;
	logic sclk_rise;
	logic sclk_fall;
	logic [2:0] bit_cnt;
	logic [7:0] rx_shift;
	logic [7:0] tx_shift;
	logic [7:0] tx_hold;

	assign sclk_rise = sclk_q[1] & ~sclk_q[2];
	assign sclk_fall = ~sclk_q[1] & sclk_q[2];
	assign sclk_edge = sclk_rise | sclk_fall;
	assign cs_active = ~cs_q[1];
	assign cs_rise = cs_q[1] & ~cs_q[2];
	assign rx_byte = rx_shift;
	// mode 0, MSB first
	assign miso = tx_shift[7];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sclk_q <= 3'b000;
			cs_q <= 3'b111;
			mosi_q <= 2'b00;
			bit_cnt <= 3'd0;
			rx_valid <= 1'b0;
		end else begin
			sclk_q <= {sclk_q[1:0], sclk};
			cs_q <= {cs_q[1:0], cs_n};
			mosi_q <= {mosi_q[0], mosi};
			rx_valid <= 1'b0;
			// bit position only counts while selected
			if (!cs_active) begin
				bit_cnt <= 3'd0;
			end else if (sclk_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				// eighth rising edge completes the byte
				rx_valid <= (bit_cnt == 3'd7);
			end
		end
	end

	always_ff @(posedge clk) begin
		// sample mosi on the rising edge
		if (cs_active && sclk_rise)
			rx_shift <= {rx_shift[6:0], mosi_q[1]};

		// falling edge at a byte boundary starts the next byte from the hold register
		// other falling edges move the next bit up
		if (!cs_active)
			tx_shift <= idle_byte;
		else if (sclk_fall)
			tx_shift <= (bit_cnt == 3'd0) ? tx_hold : {tx_shift[6:0], 1'b1};

		// hold falls back to filler once consumed
		if (!cs_active)
			tx_hold <= idle_byte;
		else if (tx_load)
			tx_hold <= tx_byte;
		else if (sclk_fall && bit_cnt == 3'd0)
			tx_hold <= idle_byte;
	end

endmodule

/* spi_flash_emu.f */
source/flash_emu_pkg.sv
source/host_map_pkg.sv
source/spi_shifter.sv
source/spi_idle_timer.sv
source/flash_sequencer.sv
source/image_ram.sv
source/host_apb_regs.sv
source/spi_flash_emu.sv
dv/spi_flash_emu_assert.sv
dv/spi_flash_emu_tb.sv
